//--- verilog/clk_rst_pkg.sv
package clk_rst_pkg;

  //************************************************************
  // widths with a meaning
  //************************************************************

  // wishbone data word and register word address
  typedef logic [31:0] wb_dat_t;
  typedef logic [1:0]  wb_adr_t;

  // requested phase steps, accumulated signed position
  typedef logic [7:0]         ps_count_t;
  typedef logic signed [15:0] phase_pos_t;

  // saturating count of lock-loss events
  typedef logic [7:0] loss_count_t;

  //************************************************************
  // counts
  //************************************************************

  // cycles that rstdiv0 stays high once lock and rdy are good
  localparam int RST_SYNC_NUM = 8;
  // cycles to wait for psdone before the request is aborted
  localparam int PS_TIMEOUT   = 64;

  //************************************************************
  // register map
  //************************************************************

  localparam wb_adr_t REG_STATUS    = 2'd0;
  localparam wb_adr_t REG_PS_CTRL   = 2'd1;
  localparam wb_adr_t REG_PS_POS    = 2'd2;
  localparam wb_adr_t REG_LOCK_LOSS = 2'd3;

  // status bits
  localparam int STAT_LOCK = 0;
  localparam int STAT_RDY  = 1;
  localparam int STAT_RUN  = 2;
  localparam int STAT_BUSY = 3;
  localparam int STAT_TMO  = 4;

  // ps_ctrl keeps the steps in [7:0] and the direction in this bit
  localparam int PS_INC_BIT = 8;

  // phase-shift sequencer states
  typedef enum logic [1:0] {idle, step, wait_done} ps_state_t;

endpackage

//--- verilog/reset_release.sv
`timescale 1ns/1ps

module reset_release (
  input  logic clk_bufg,
  input  logic rst_tmp,
  input  logic pll_lock,
  input  logic iodelay_ctrl_rdy,
  output logic rstdiv0
);

  import clk_rst_pkg::*;

  //************************************************************
  // reset release chain
  //************************************************************

  // any bad condition holds the whole design in reset
  logic                    rst_any;
  // stretch register, all ones while rst_any is high
  logic [RST_SYNC_NUM-1:0] rst_sync_r;

  // raw reset, clock generator not locked, idelayctrl not ready
  assign rst_any = rst_tmp | ~pll_lock | ~iodelay_ctrl_rdy;

  // assert at once without a clock, release after RST_SYNC_NUM edges
  always_ff @(posedge clk_bufg or posedge rst_any) begin
    if (rst_any) begin
      rst_sync_r <= '1;
    end else begin
      // zeros walk toward the msb
      rst_sync_r <= {rst_sync_r[RST_SYNC_NUM-2:0], 1'b0};
    end
  end

  // last stage drives the fabric reset
  assign rstdiv0 = rst_sync_r[RST_SYNC_NUM-1];

endmodule

//--- verilog/phase_shift_seq.sv
`timescale 1ns/1ps

module phase_shift_seq (
  input  logic                   clk_bufg,
  input  logic                   rst_tmp,
  input  logic                   ps_start,
  input  clk_rst_pkg::ps_count_t ps_steps,
  input  logic                   ps_inc,
  input  logic                   ps_clear,
  input  logic                   psdone,
  output logic                   psen,
  output logic                   psincdec,
  output logic                   ps_busy,
  output logic                   ps_timeout,
  output clk_rst_pkg::phase_pos_t ps_pos
);

  import clk_rst_pkg::*;

  localparam int TMO_W = $clog2(PS_TIMEOUT + 1);

  ps_state_t        state;
  // steps still to issue, including the one in flight
  ps_count_t        remaining;
  // latched direction, 1 moves the phase forward
  logic             dir_r;
  // cycles spent waiting for psdone
  logic [TMO_W-1:0] tmo_cnt;

  //************************************************************
  // handshake outputs
  //************************************************************

  // one psen per visit to step, direction held for the whole request
  assign psen     = (state == step);
  assign psincdec = dir_r;
  assign ps_busy  = (state != idle);

  //************************************************************
  // sequencer
  //************************************************************

  always_ff @(posedge clk_bufg or posedge rst_tmp) begin
    if (rst_tmp) begin
      state      <= idle;
      remaining  <= '0;
      dir_r      <= 1'b0;
      tmo_cnt    <= '0;
      ps_timeout <= 1'b0;
      ps_pos     <= '0;
    end else begin
      // software clears the sticky flag, a new timeout below wins
      if (ps_clear) begin
        ps_timeout <= 1'b0;
      end

      case (state)
        idle: begin
          // zero-length requests do nothing
          if (ps_start && (ps_steps != '0)) begin
            remaining <= ps_steps;
            dir_r     <= ps_inc;
            state     <= step;
          end
        end

        step: begin
          // psen is out this cycle, start the done timer
          tmo_cnt <= '0;
          state   <= wait_done;
        end

        wait_done: begin
          if (psdone) begin
            // one step taken by the generator
            if (dir_r) begin
              ps_pos <= ps_pos + phase_pos_t'(1);
            end else begin
              ps_pos <= ps_pos - phase_pos_t'(1);
            end
            remaining <= remaining - ps_count_t'(1);
            if (remaining == ps_count_t'(1)) begin
              state <= idle;
            end else begin
              state <= step;
            end
          end else if (tmo_cnt == TMO_W'(PS_TIMEOUT - 1)) begin
            // generator never answered, drop the rest of the request
            ps_timeout <= 1'b1;
            remaining  <= '0;
            state      <= idle;
          end else begin
            tmo_cnt <= tmo_cnt + TMO_W'(1);
          end
        end

        default: begin
          state <= idle;
        end
      endcase
    end
  end

endmodule

//--- verilog/lock_monitor.sv
`timescale 1ns/1ps

module lock_monitor (
  input  logic                     clk_bufg,
  input  logic                     rst_tmp,
  input  logic                     pll_lock,
  input  logic                     loss_clear,
  output logic                     lock_sync,
  output clk_rst_pkg::loss_count_t loss_count
);

  import clk_rst_pkg::*;

  // first synchronizer stage, lock_sync is the second
  logic lock_meta;
  // previous synchronized value for edge detection
  logic lock_prev;
  // set once the generator has locked at least once
  logic armed;
  logic lock_fall;

  // only a loss after a real lock counts
  assign lock_fall = armed & lock_prev & ~lock_sync;

  //************************************************************
  // synchronizer and edge detect
  //************************************************************

  always_ff @(posedge clk_bufg or posedge rst_tmp) begin
    if (rst_tmp) begin
      lock_meta <= 1'b0;
      lock_sync <= 1'b0;
      lock_prev <= 1'b0;
      armed     <= 1'b0;
    end else begin
      lock_meta <= pll_lock;
      lock_sync <= lock_meta;
      lock_prev <= lock_sync;
      // stays set, a count clear does not disarm
      if (lock_sync) begin
        armed <= 1'b1;
      end
    end
  end

  // saturating loss counter
  always_ff @(posedge clk_bufg or posedge rst_tmp) begin
    if (rst_tmp) begin
      loss_count <= '0;
    end else if (loss_clear) begin
      loss_count <= '0;
    end else if (lock_fall && (loss_count != '1)) begin
      loss_count <= loss_count + loss_count_t'(1);
    end
  end

endmodule

//--- verilog/clk_infra_regs.sv
`timescale 1ns/1ps

module clk_infra_regs (
  input  logic                     clk_bufg,
  input  logic                     rst_tmp,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  clk_rst_pkg::wb_adr_t     wb_adr,
  input  clk_rst_pkg::wb_dat_t     wb_dat_w,
  output clk_rst_pkg::wb_dat_t     wb_dat_r,
  output logic                     wb_ack,
  input  logic                     lock_sync,
  input  logic                     iodelay_ctrl_rdy,
  input  logic                     rstdiv0,
  input  logic                     ps_busy,
  input  logic                     ps_timeout,
  input  clk_rst_pkg::phase_pos_t  ps_pos,
  input  clk_rst_pkg::loss_count_t loss_count,
  output logic                     ps_start,
  output clk_rst_pkg::ps_count_t   ps_steps,
  output logic                     ps_inc,
  output logic                     ps_clear,
  output logic                     loss_clear
);

  import clk_rst_pkg::*;

  // new classic request, not yet acked
  logic    wb_req;
  logic    wb_wr;
  // last word written to ps_ctrl
  wb_dat_t ps_ctrl_r;
  wb_dat_t status_word;

  assign wb_req = wb_cyc & wb_stb & ~wb_ack;
  assign wb_wr  = wb_req & wb_we;

  //************************************************************
  // bus cycle and write strobes
  //************************************************************

  always_ff @(posedge clk_bufg or posedge rst_tmp) begin
    if (rst_tmp) begin
      wb_ack     <= 1'b0;
      ps_ctrl_r  <= '0;
      ps_start   <= 1'b0;
      ps_clear   <= 1'b0;
      loss_clear <= 1'b0;
    end else begin
      // single ack cycle, no wait states
      wb_ack     <= wb_req;
      // strobes are one-cycle pulses
      ps_start   <= 1'b0;
      ps_clear   <= 1'b0;
      loss_clear <= 1'b0;
      if (wb_wr) begin
        case (wb_adr)
          REG_STATUS: begin
            // write one to the timeout bit clears it
            ps_clear <= wb_dat_w[STAT_TMO];
          end
          REG_PS_CTRL: begin
            ps_ctrl_r <= wb_dat_w;
            ps_start  <= 1'b1;
          end
          REG_LOCK_LOSS: begin
            loss_clear <= 1'b1;
          end
          default: begin
            // position is read only
          end
        endcase
      end
    end
  end

  // request fields come from the stored word, valid with ps_start
  assign ps_steps = ps_ctrl_r[$bits(ps_count_t)-1:0];
  assign ps_inc   = ps_ctrl_r[PS_INC_BIT];

  //************************************************************
  // read mux
  //************************************************************

  always_comb begin
    status_word            = '0;
    status_word[STAT_LOCK] = lock_sync;
    status_word[STAT_RDY]  = iodelay_ctrl_rdy;
    // run means the fabric is out of reset
    status_word[STAT_RUN]  = ~rstdiv0;
    status_word[STAT_BUSY] = ps_busy;
    status_word[STAT_TMO]  = ps_timeout;
  end

  // master holds adr until ack, so data is stable in the ack cycle
  always_comb begin
    case (wb_adr)
      REG_STATUS:  wb_dat_r = status_word;
      REG_PS_CTRL: wb_dat_r = ps_ctrl_r;
      // signed position, sign extended
      REG_PS_POS: begin
        wb_dat_r = {{($bits(wb_dat_t) - $bits(phase_pos_t)){ps_pos[$bits(phase_pos_t)-1]}},
                    ps_pos};
      end
      default: begin
        wb_dat_r = {{($bits(wb_dat_t) - $bits(loss_count_t)){1'b0}}, loss_count};
      end
    endcase
  end

endmodule

//--- verilog/clk_infra_top.sv
`timescale 1ns/1ps

module clk_infra_top (
  input  logic                 clk_bufg,
  input  logic                 rst_tmp,
  input  logic                 pll_lock,
  input  logic                 psdone,
  input  logic                 iodelay_ctrl_rdy,
  output logic                 psen,
  output logic                 psincdec,
  output logic                 rstdiv0,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  clk_rst_pkg::wb_adr_t wb_adr,
  input  clk_rst_pkg::wb_dat_t wb_dat_w,
  output clk_rst_pkg::wb_dat_t wb_dat_r,
  output logic                 wb_ack
);

  import clk_rst_pkg::*;

  //************************************************************
  // register block to sequencer and monitor
  //************************************************************

  logic        ps_start;
  ps_count_t   ps_steps;
  logic        ps_inc;
  logic        ps_clear;
  logic        ps_busy;
  logic        ps_timeout;
  phase_pos_t  ps_pos;
  logic        loss_clear;
  logic        lock_sync;
  loss_count_t loss_count;

  // fabric reset from lock, rdy and the raw reset
  reset_release reset_release_inst (
    .clk_bufg         (clk_bufg),
    .rst_tmp          (rst_tmp),
    .pll_lock         (pll_lock),
    .iodelay_ctrl_rdy (iodelay_ctrl_rdy),
    .rstdiv0          (rstdiv0)
  );

  // fine phase steps toward the clock generator
  phase_shift_seq phase_shift_seq_inst (
    .clk_bufg   (clk_bufg),
    .rst_tmp    (rst_tmp),
    .ps_start   (ps_start),
    .ps_steps   (ps_steps),
    .ps_inc     (ps_inc),
    .ps_clear   (ps_clear),
    .psdone     (psdone),
    .psen       (psen),
    .psincdec   (psincdec),
    .ps_busy    (ps_busy),
    .ps_timeout (ps_timeout),
    .ps_pos     (ps_pos)
  );

  lock_monitor lock_monitor_inst (
    .clk_bufg   (clk_bufg),
    .rst_tmp    (rst_tmp),
    .pll_lock   (pll_lock),
    .loss_clear (loss_clear),
    .lock_sync  (lock_sync),
    .loss_count (loss_count)
  );

  // wishbone slave with status and control
  clk_infra_regs clk_infra_regs_inst (
    .clk_bufg         (clk_bufg),
    .rst_tmp          (rst_tmp),
    .wb_cyc           (wb_cyc),
    .wb_stb           (wb_stb),
    .wb_we            (wb_we),
    .wb_adr           (wb_adr),
    .wb_dat_w         (wb_dat_w),
    .wb_dat_r         (wb_dat_r),
    .wb_ack           (wb_ack),
    .lock_sync        (lock_sync),
    .iodelay_ctrl_rdy (iodelay_ctrl_rdy),
    .rstdiv0          (rstdiv0),
    .ps_busy          (ps_busy),
    .ps_timeout       (ps_timeout),
    .ps_pos           (ps_pos),
    .loss_count       (loss_count),
    .ps_start         (ps_start),
    .ps_steps         (ps_steps),
    .ps_inc           (ps_inc),
    .ps_clear         (ps_clear),
    .loss_clear       (loss_clear)
  );

endmodule

//--- verification/tb_clk_infra.sv
`timescale 1ns/1ps

module tb_clk_infra;

  import clk_rst_pkg::*;

  localparam logic [31:0] SEED = 32'hafa5_ce57;

  // dut inputs start in a known state
  logic    clk_bufg         = 1'b0;
  logic    rst_tmp          = 1'b1;
  logic    pll_lock         = 1'b1;
  logic    psdone           = 1'b0;
  logic    iodelay_ctrl_rdy = 1'b1;
  logic    wb_cyc           = 1'b0;
  logic    wb_stb           = 1'b0;
  logic    wb_we            = 1'b0;
  wb_adr_t wb_adr           = '0;
  wb_dat_t wb_dat_w         = '0;
  // dut outputs
  logic    psen;
  logic    psincdec;
  logic    rstdiv0;
  wb_dat_t wb_dat_r;
  logic    wb_ack;

  int          checks    = 0;
  int          errors    = 0;
  // separate random streams for stimulus and the generator model
  logic [31:0] stim_rng  = SEED;
  logic [31:0] model_rng = SEED;
  // generator model stops answering psen while set
  logic        drop_done = 1'b0;
  // direction of every psen seen
  logic        psen_dirs[$];
  // reference model state
  int          exp_pos   = 0;
  int          exp_loss  = 0;
  logic        exp_tmo   = 1'b0;

  // 100 ns clock
  always #50 clk_bufg = ~clk_bufg;

  clk_infra_top clk_infra_top_inst (
    .clk_bufg         (clk_bufg),
    .rst_tmp          (rst_tmp),
    .pll_lock         (pll_lock),
    .psdone           (psdone),
    .iodelay_ctrl_rdy (iodelay_ctrl_rdy),
    .psen             (psen),
    .psincdec         (psincdec),
    .rstdiv0          (rstdiv0),
    .wb_cyc           (wb_cyc),
    .wb_stb           (wb_stb),
    .wb_we            (wb_we),
    .wb_adr           (wb_adr),
    .wb_dat_w         (wb_dat_w),
    .wb_dat_r         (wb_dat_r),
    .wb_ack           (wb_ack)
  );

  //************************************************************
  // helpers
  //************************************************************

  // 32-bit xorshift step
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // status word built from the register map bit positions
  function automatic wb_dat_t expected_status(input logic lock, input logic rdy,
                                              input logic run, input logic busy,
                                              input logic tmo);
    wb_dat_t w;
    w            = '0;
    w[STAT_LOCK] = lock;
    w[STAT_RDY]  = rdy;
    w[STAT_RUN]  = run;
    w[STAT_BUSY] = busy;
    w[STAT_TMO]  = tmo;
    return w;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("error %s: expected 0x%08h, actual 0x%08h", name, exp, act);
    end
  endtask

  // one classic cycle with the request driven on a rising edge and ack seen on a falling one
  task automatic wb_xfer(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                         output wb_dat_t rdat);
    int n;
    n    = 0;
    rdat = '0;
    @(posedge clk_bufg);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdat;
    // the slave adds no wait states
    do begin
      @(negedge clk_bufg);
      n++;
    end while ((wb_ack !== 1'b1) && (n < 16));
    checks++;
    assert (wb_ack === 1'b1) else begin
      errors++;
      $display("no ack from the Wishbone slave for address %0d", adr);
    end
    rdat = wb_dat_r;
    @(posedge clk_bufg);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    // ack must be gone the cycle after
    @(negedge clk_bufg);
    checks++;
    assert (wb_ack === 1'b0) else begin
      errors++;
      $display("ack held for more than one cycle at address %0d", adr);
    end
  endtask

  task automatic wb_write(input wb_adr_t adr, input wb_dat_t wdat);
    wb_dat_t discard;
    wb_xfer(1'b1, adr, wdat, discard);
  endtask

  task automatic wb_read(input wb_adr_t adr, output wb_dat_t rdat);
    wb_xfer(1'b0, adr, '0, rdat);
  endtask

  task automatic check_read(input string name, input wb_adr_t adr, input wb_dat_t exp);
    wb_dat_t rd;
    wb_read(adr, rd);
    compare_value(name, exp, rd);
  endtask

  // poll status until the sequencer is idle
  task automatic wait_ps_idle(input string name);
    wb_dat_t rd;
    int      polls;
    polls = 0;
    do begin
      wb_read(REG_STATUS, rd);
      polls++;
    end while (rd[STAT_BUSY] && (polls < 400));
    checks++;
    assert (!rd[STAT_BUSY]) else begin
      errors++;
      $display("%s: phase shift still busy after %0d status polls", name, polls);
    end
  endtask

  // count rising edges until rstdiv0 drops
  // the caller sits on the edge that frees the reset
  task automatic measure_release(input string name);
    int edges;
    edges = 0;
    do begin
      @(posedge clk_bufg);
      edges++;
      @(negedge clk_bufg);
    end while (rstdiv0 && (edges < 4 * RST_SYNC_NUM));
    compare_value(name, RST_SYNC_NUM, edges);
  endtask

  //************************************************************
  // clock generator model
  //************************************************************

  // answers each psen with one psdone cycle 1 to 20 cycles later
  always begin : clock_gen_model
    int delay;
    @(negedge clk_bufg);
    if (psen === 1'b1) begin
      psen_dirs.push_back(psincdec);
      if (!drop_done) begin
        model_rng = xorshift32(model_rng);
        delay     = 1 + int'(model_rng % 32'd20);
        repeat (delay) @(posedge clk_bufg);
        psdone <= 1'b1;
        @(posedge clk_bufg);
        psdone <= 1'b0;
      end
    end
  end

  //************************************************************
  // test sequence
  //************************************************************

  initial begin : main_seq
    wb_dat_t     rd;
    logic [31:0] wdat;
    int          steps;
    int          inc;
    int          base;
    int          pulses;

    // outputs in reset
    @(negedge clk_bufg);
    compare_value("reset_rstdiv0", 32'd1, 32'(rstdiv0));
    compare_value("reset_psen", 32'd0, 32'(psen));
    compare_value("reset_psincdec", 32'd0, 32'(psincdec));
    compare_value("reset_ack", 32'd0, 32'(wb_ack));
    repeat (2) @(posedge clk_bufg);
    rst_tmp <= 1'b0;

    // 1. reset release and relock
    measure_release("release_after_reset");
    check_read("status_after_release", REG_STATUS,
               expected_status(1'b1, 1'b1, 1'b1, 1'b0, exp_tmo));
    @(posedge clk_bufg);
    pll_lock <= 1'b0;
    // rstdiv0 rises without waiting for a clock
    @(negedge clk_bufg);
    compare_value("rstdiv0_on_lock_loss", 32'd1, 32'(rstdiv0));
    // read lands after the two synchronizer stages
    check_read("status_unlocked", REG_STATUS,
               expected_status(1'b0, 1'b1, 1'b0, 1'b0, exp_tmo));
    // monitor was armed so this drop counts
    exp_loss++;
    @(posedge clk_bufg);
    pll_lock <= 1'b1;
    measure_release("release_after_relock");
    check_read("status_relocked", REG_STATUS,
               expected_status(1'b1, 1'b1, 1'b1, 1'b0, exp_tmo));

    // idelayctrl losing ready also holds the fabric in reset
    @(posedge clk_bufg);
    iodelay_ctrl_rdy <= 1'b0;
    @(negedge clk_bufg);
    compare_value("rstdiv0_on_rdy_loss", 32'd1, 32'(rstdiv0));
    check_read("status_not_ready", REG_STATUS,
               expected_status(1'b1, 1'b0, 1'b0, 1'b0, exp_tmo));
    @(posedge clk_bufg);
    iodelay_ctrl_rdy <= 1'b1;
    measure_release("release_after_ready");
    check_read("status_ready", REG_STATUS,
               expected_status(1'b1, 1'b1, 1'b1, 1'b0, exp_tmo));

    // 2. readback of a zero-step word that starts no request
    stim_rng = xorshift32(stim_rng);
    wdat     = stim_rng & 32'hffff_ff00;
    wb_write(REG_PS_CTRL, wdat);
    check_read("ps_ctrl_readback", REG_PS_CTRL, wdat);
    check_read("ps_pos_after_zero_request", REG_PS_POS, 32'(exp_pos));

    // 3. random phase requests
    repeat (8) begin
      stim_rng = xorshift32(stim_rng);
      steps    = 1 + int'(stim_rng % 32'd24);
      inc      = int'(stim_rng[16]);
      base     = psen_dirs.size();
      wb_write(REG_PS_CTRL, 32'(inc << PS_INC_BIT) | 32'(steps));
      wait_ps_idle("phase_request");
      exp_pos += (inc != 0) ? steps : -steps;
      check_read("ps_pos", REG_PS_POS, 32'(exp_pos));
      compare_value("psen_count", 32'(steps), 32'(psen_dirs.size() - base));
      for (int i = base; i < psen_dirs.size(); i++) begin
        compare_value("psincdec", 32'(inc), 32'(psen_dirs[i]));
      end
    end

    // 4. with the generator silent the request aborts after the first step
    drop_done = 1'b1;
    stim_rng  = xorshift32(stim_rng);
    steps     = 2 + int'(stim_rng % 32'd8);
    base      = psen_dirs.size();
    wb_write(REG_PS_CTRL, 32'(1 << PS_INC_BIT) | 32'(steps));
    // still waiting for the first psdone
    wb_read(REG_STATUS, rd);
    compare_value("status_busy", 32'd1, 32'(rd[STAT_BUSY]));
    wait_ps_idle("timeout_request");
    exp_tmo = 1'b1;
    compare_value("timeout_psen_count", 32'd1, 32'(psen_dirs.size() - base));
    wb_read(REG_STATUS, rd);
    compare_value("status_tmo_set", 32'(exp_tmo), 32'(rd[STAT_TMO]));
    check_read("timeout_pos_held", REG_PS_POS, 32'(exp_pos));
    wb_write(REG_STATUS, 32'(1 << STAT_TMO));
    exp_tmo = 1'b0;
    wb_read(REG_STATUS, rd);
    compare_value("status_tmo_cleared", 32'(exp_tmo), 32'(rd[STAT_TMO]));
    drop_done = 1'b0;

    // 5. lock-loss counting
    check_read("loss_count_start", REG_LOCK_LOSS, 32'(exp_loss));
    wb_write(REG_LOCK_LOSS, '0);
    exp_loss = 0;
    stim_rng = xorshift32(stim_rng);
    pulses   = 1 + int'(stim_rng % 32'd6);
    repeat (pulses) begin
      @(posedge clk_bufg);
      pll_lock <= 1'b0;
      stim_rng = xorshift32(stim_rng);
      // low long enough for the synchronizer
      repeat (2 + int'(stim_rng % 32'd4)) @(posedge clk_bufg);
      pll_lock <= 1'b1;
      stim_rng = xorshift32(stim_rng);
      // high long enough for the count to land
      repeat (4 + int'(stim_rng % 32'd5)) @(posedge clk_bufg);
      exp_loss++;
    end
    check_read("loss_count_pulses", REG_LOCK_LOSS, 32'(exp_loss));
    wb_write(REG_LOCK_LOSS, '0);
    exp_loss = 0;
    check_read("loss_count_cleared", REG_LOCK_LOSS, 32'(exp_loss));

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
verilog/clk_rst_pkg.sv
verilog/reset_release.sv
verilog/phase_shift_seq.sv
verilog/lock_monitor.sv
verilog/clk_infra_regs.sv
verilog/clk_infra_top.sv
verification/tb_clk_infra.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the clock and reset testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_clk_infra \
  -Mdir obj_dir -o sim_clk_infra

output="$(./obj_dir/sim_clk_infra)"
echo "$output"

if echo "$output" | grep -q "^TEST PASSED$"; then
  exit 0
else
  exit 1
fi
